// File: include/cpu_cfg.svh
/*
 * Size settings for the five-stage pipeline.
 * Memory depths are in words; both memories are word addressed by the
 * byte address with its two low bits dropped.
 * CPU_DATA_W must stay at 32, since the instruction fields assume it.
 */
`ifndef CPU_CFG_SVH
`define CPU_CFG_SVH

// word and register index widths
`define CPU_DATA_W 32
`define CPU_REG_ADDR_W 5

// 512 instruction words, 1024 data words
`define CPU_IMEM_ADDR_W 9
`define CPU_DMEM_ADDR_W 10

`endif

// File: design/cpu_pkg.sv
/*
 * Types shared by the pipeline stages.
 * Encodings follow the classic three-register instruction set.
 * Opcodes and functs that are not listed here decode as no-ops.
 */
`include "cpu_cfg.svh"

package cpu_pkg;

   typedef logic [`CPU_DATA_W-1:0] word_t;
   typedef logic [`CPU_REG_ADDR_W-1:0] reg_addr_t;

   typedef enum logic [5:0] {
      OP_RTYPE = 6'd0,
      OP_ADDI  = 6'd8,
      OP_LW    = 6'd35,
      OP_SW    = 6'd43
   } opcode_e;

   typedef enum logic [5:0] {
      FN_ADD = 6'd32,
      FN_SUB = 6'd34,
      FN_AND = 6'd36,
      FN_OR  = 6'd37,
      FN_SLT = 6'd42
   } funct_e;

   // ALU_NONE marks an instruction that does nothing
   typedef enum logic [2:0] {
      ALU_ADD,
      ALU_SUB,
      ALU_AND,
      ALU_OR,
      ALU_SLT,
      ALU_NONE
   } alu_op_e;

endpackage

// File: design/fetch_stage.sv
/*
 * Program counter, instruction memory and IF/ID register.
 * The PC is a byte address stepping by 4; no branches or jumps.
 * The external write port is only legal while enable is low.
 * The instruction memory has no reset and must be loaded before a run.
 */
`timescale 1ns/1ps
`include "cpu_cfg.svh"

module fetch_stage import cpu_pkg::*; (
   input  logic                        clk,
   input  logic                        rst,
   input  logic                        enable,
   input  logic                        stall,
   input  logic                        imem_wen,
   input  logic [`CPU_IMEM_ADDR_W-1:0] imem_addr,
   input  word_t                       imem_wdata,
   output word_t                       if_instr
);

   word_t pc;
   word_t imem [2**`CPU_IMEM_ADDR_W];
   logic  advance;

   assign advance = enable && !stall;

   always_ff @(posedge clk) begin
      if (imem_wen) begin
         imem[imem_addr] <= imem_wdata;
      end
   end

   // pc and IF/ID move together; reset leaves a no-op in IF/ID
   always_ff @(posedge clk) begin
      if (rst) begin
         pc       <= '0;
         if_instr <= '0;
      end else if (advance) begin
         pc       <= pc + 32'd4;
         if_instr <= imem[pc[`CPU_IMEM_ADDR_W+1:2]];
      end
   end

   // program loading and running must not overlap
   a_imem_wen_idle: assert property (
      @(posedge clk) disable iff (rst) !(imem_wen && enable)
   );

endmodule

// File: design/decode_stage.sv
/*
 * Control decode, register file, load-use hazard check and ID/EX.
 * The register file is write-through and register 0 reads as zero.
 * A load in ID/EX whose rt matches rs or rt in IF/ID stalls one cycle,
 * even when the younger instruction does not use rt.
 */
`timescale 1ns/1ps
`include "cpu_cfg.svh"

module decode_stage import cpu_pkg::*; (
   input  logic      clk,
   input  logic      rst,
   input  logic      enable,
   input  word_t     if_instr,
   input  logic      wb_reg_write,
   input  reg_addr_t wb_waddr,
   input  word_t     wb_wdata,
   output logic      stall,
   output alu_op_e   ex_alu_op,
   output logic      ex_alu_src,
   output logic      ex_mem_write,
   output logic      ex_mem_to_reg,
   output logic      ex_reg_write,
   output reg_addr_t ex_rs,
   output reg_addr_t ex_rt,
   output reg_addr_t ex_waddr,
   output word_t     ex_rs_data,
   output word_t     ex_rt_data,
   output word_t     ex_imm
);

   opcode_e   opcode;
   funct_e    funct;
   reg_addr_t rs;
   reg_addr_t rt;
   reg_addr_t rd;
   alu_op_e   alu_op;
   logic      alu_src;
   logic      mem_write;
   logic      mem_to_reg;
   logic      reg_write;
   logic      reg_dst;
   word_t     rs_data;
   word_t     rt_data;
   word_t     imm;
   word_t     regs [2**`CPU_REG_ADDR_W];

   assign opcode = opcode_e'(if_instr[31:26]);
   assign funct  = funct_e'(if_instr[5:0]);
   assign rs     = if_instr[25:21];
   assign rt     = if_instr[20:16];
   assign rd     = if_instr[15:11];
   assign imm    = {{(`CPU_DATA_W-16){if_instr[15]}}, if_instr[15:0]};

   always_comb begin
      alu_op     = ALU_NONE;
      alu_src    = 1'b0;
      mem_write  = 1'b0;
      mem_to_reg = 1'b0;
      reg_write  = 1'b0;
      reg_dst    = 1'b0;
      case (opcode)
         OP_RTYPE: begin
            reg_dst = 1'b1;
            case (funct)
               FN_ADD:  alu_op = ALU_ADD;
               FN_SUB:  alu_op = ALU_SUB;
               FN_AND:  alu_op = ALU_AND;
               FN_OR:   alu_op = ALU_OR;
               FN_SLT:  alu_op = ALU_SLT;
               default: alu_op = ALU_NONE;
            endcase
            reg_write = (alu_op != ALU_NONE);
         end
         OP_ADDI: begin
            alu_op    = ALU_ADD;
            alu_src   = 1'b1;
            reg_write = 1'b1;
         end
         OP_LW: begin
            alu_op     = ALU_ADD;
            alu_src    = 1'b1;
            mem_to_reg = 1'b1;
            reg_write  = 1'b1;
         end
         OP_SW: begin
            alu_op    = ALU_ADD;
            alu_src   = 1'b1;
            mem_write = 1'b1;
         end
         default: alu_op = ALU_NONE;
      endcase
   end

   // write-through read, so a writeback in this cycle is seen here
   assign rs_data = (rs == '0) ? '0 :
                    (wb_reg_write && wb_waddr == rs) ? wb_wdata : regs[rs];
   assign rt_data = (rt == '0) ? '0 :
                    (wb_reg_write && wb_waddr == rt) ? wb_wdata : regs[rt];

   always_ff @(posedge clk) begin
      if (rst) begin
         for (int i = 0; i < 2**`CPU_REG_ADDR_W; i++) begin
            regs[i] <= '0;
         end
      end else if (enable && wb_reg_write && wb_waddr != '0) begin
         regs[wb_waddr] <= wb_wdata;
      end
   end

   // lw uses mem_to_reg as its load marker
   assign stall = ex_mem_to_reg && (ex_rt == rs || ex_rt == rt);

   // a bubble also clears the register fields so it never matches a forward
   always_ff @(posedge clk) begin
      if (rst || (enable && stall)) begin
         ex_alu_op     <= ALU_NONE;
         ex_alu_src    <= 1'b0;
         ex_mem_write  <= 1'b0;
         ex_mem_to_reg <= 1'b0;
         ex_reg_write  <= 1'b0;
         ex_rs         <= '0;
         ex_rt         <= '0;
         ex_waddr      <= '0;
      end else if (enable) begin
         ex_alu_op     <= alu_op;
         ex_alu_src    <= alu_src;
         ex_mem_write  <= mem_write;
         ex_mem_to_reg <= mem_to_reg;
         ex_reg_write  <= reg_write;
         ex_rs         <= rs;
         ex_rt         <= rt;
         ex_waddr      <= reg_dst ? rd : rt;
      end
   end

   always_ff @(posedge clk) begin
      if (enable) begin
         ex_rs_data <= rs_data;
         ex_rt_data <= rt_data;
         ex_imm     <= imm;
      end
   end

   // an opcode or funct outside the supported set decodes as a no-op
   a_nop_no_write: assert property (
      @(posedge clk) disable iff (rst)
      !(opcode inside {OP_ADDI, OP_LW, OP_SW} ||
        (opcode == OP_RTYPE && funct inside {FN_ADD, FN_SUB, FN_AND, FN_OR, FN_SLT}))
      |-> !reg_write
   );

endmodule

// File: design/execute_stage.sv
/*
 * Forwarding, operand select, ALU and EX/MEM register.
 * Forwarding priority is EX/MEM, then MEM/WB, then the register file.
 * Register 0 is never forwarded. A load in EX/MEM cannot forward;
 * the load-use stall in decode keeps that case from arising.
 */
`timescale 1ns/1ps

module execute_stage import cpu_pkg::*; (
   input  logic      clk,
   input  logic      rst,
   input  logic      enable,
   input  alu_op_e   ex_alu_op,
   input  logic      ex_alu_src,
   input  logic      ex_mem_write,
   input  logic      ex_mem_to_reg,
   input  logic      ex_reg_write,
   input  reg_addr_t ex_rs,
   input  reg_addr_t ex_rt,
   input  reg_addr_t ex_waddr,
   input  word_t     ex_rs_data,
   input  word_t     ex_rt_data,
   input  word_t     ex_imm,
   input  logic      wb_reg_write,
   input  reg_addr_t wb_waddr,
   input  word_t     wb_wdata,
   output word_t     mem_alu_out,
   output word_t     mem_store_data,
   output logic      mem_mem_write,
   output logic      mem_mem_to_reg,
   output logic      mem_reg_write,
   output reg_addr_t mem_waddr
);

   logic  fwd_a_mem;
   logic  fwd_a_wb;
   logic  fwd_b_mem;
   logic  fwd_b_wb;
   word_t op_a;
   word_t rt_fwd;
   word_t op_b;
   word_t alu_out;

   assign fwd_a_mem = mem_reg_write && (mem_waddr != '0) && (mem_waddr == ex_rs);
   assign fwd_a_wb  = wb_reg_write && (wb_waddr != '0) && (wb_waddr == ex_rs);
   assign fwd_b_mem = mem_reg_write && (mem_waddr != '0) && (mem_waddr == ex_rt);
   assign fwd_b_wb  = wb_reg_write && (wb_waddr != '0) && (wb_waddr == ex_rt);

   assign op_a = fwd_a_mem ? mem_alu_out :
                 fwd_a_wb  ? wb_wdata    : ex_rs_data;

   // forwarded rt feeds both the immediate mux and the store data
   assign rt_fwd = fwd_b_mem ? mem_alu_out :
                   fwd_b_wb  ? wb_wdata    : ex_rt_data;
   assign op_b   = ex_alu_src ? ex_imm : rt_fwd;

   always_comb begin
      case (ex_alu_op)
         ALU_ADD: alu_out = op_a + op_b;
         ALU_SUB: alu_out = op_a - op_b;
         ALU_AND: alu_out = op_a & op_b;
         ALU_OR:  alu_out = op_a | op_b;
         ALU_SLT: alu_out = ($signed(op_a) < $signed(op_b)) ? word_t'(1) : '0;
         default: alu_out = '0;
      endcase
   end

   always_ff @(posedge clk) begin
      if (rst) begin
         mem_mem_write  <= 1'b0;
         mem_mem_to_reg <= 1'b0;
         mem_reg_write  <= 1'b0;
      end else if (enable) begin
         mem_mem_write  <= ex_mem_write;
         mem_mem_to_reg <= ex_mem_to_reg;
         mem_reg_write  <= ex_reg_write;
      end
   end

   always_ff @(posedge clk) begin
      if (enable) begin
         mem_alu_out    <= alu_out;
         mem_store_data <= rt_fwd;
         mem_waddr      <= ex_waddr;
      end
   end

   // holds only if decode stalled the dependent instruction behind the load
   a_no_load_forward: assert property (
      @(posedge clk) disable iff (rst) (fwd_a_mem || fwd_b_mem) |-> !mem_mem_to_reg
   );

endmodule

// File: design/memory_stage.sv
/*
 * Data memory, MEM/WB register and writeback select.
 * The pipeline indexes data memory by bits 11:2 of the ALU result.
 * The external port is word indexed; writes are only legal while
 * enable is low. The external read is combinational and zero when idle.
 */
`timescale 1ns/1ps
`include "cpu_cfg.svh"

module memory_stage import cpu_pkg::*; (
   input  logic                        clk,
   input  logic                        rst,
   input  logic                        enable,
   input  word_t                       mem_alu_out,
   input  word_t                       mem_store_data,
   input  logic                        mem_mem_write,
   input  logic                        mem_mem_to_reg,
   input  logic                        mem_reg_write,
   input  reg_addr_t                   mem_waddr,
   input  logic [`CPU_DMEM_ADDR_W-1:0] dmem_addr,
   input  logic                        dmem_wen,
   input  logic                        dmem_ren,
   input  word_t                       dmem_wdata,
   output word_t                       dmem_rdata,
   output logic                        wb_reg_write,
   output reg_addr_t                   wb_waddr,
   output word_t                       wb_wdata
);

   word_t                       dmem [2**`CPU_DMEM_ADDR_W];
   logic [`CPU_DMEM_ADDR_W-1:0] pipe_idx;
   word_t                       load_data;
   logic                        wb_mem_to_reg;
   word_t                       wb_alu_out;
   word_t                       wb_load_data;

   assign pipe_idx  = mem_alu_out[`CPU_DMEM_ADDR_W+1:2];
   assign load_data = dmem[pipe_idx];

   always_ff @(posedge clk) begin
      if (dmem_wen) begin
         dmem[dmem_addr] <= dmem_wdata;
      end else if (enable && mem_mem_write) begin
         dmem[pipe_idx] <= mem_store_data;
      end
   end

   assign dmem_rdata = dmem_ren ? dmem[dmem_addr] : '0;

   always_ff @(posedge clk) begin
      if (rst) begin
         wb_reg_write  <= 1'b0;
         wb_mem_to_reg <= 1'b0;
      end else if (enable) begin
         wb_reg_write  <= mem_reg_write;
         wb_mem_to_reg <= mem_mem_to_reg;
      end
   end

   always_ff @(posedge clk) begin
      if (enable) begin
         wb_waddr     <= mem_waddr;
         wb_alu_out   <= mem_alu_out;
         wb_load_data <= load_data;
      end
   end

   assign wb_wdata = wb_mem_to_reg ? wb_load_data : wb_alu_out;

   a_dmem_wen_idle: assert property (
      @(posedge clk) disable iff (rst) !(dmem_wen && enable)
   );

endmodule

// File: design/cpu.sv
/*
 * Five-stage pipelined processor top.
 * Load both memories with enable low, then raise enable to run.
 * Writeback lands four enabled cycles after fetch, plus one per stall.
 */
`timescale 1ns/1ps
`include "cpu_cfg.svh"

module cpu import cpu_pkg::*; (
   input  logic                        clk,
   input  logic                        rst,
   input  logic                        enable,
   input  logic                        imem_wen,
   input  logic [`CPU_IMEM_ADDR_W-1:0] imem_addr,
   input  word_t                       imem_wdata,
   input  logic [`CPU_DMEM_ADDR_W-1:0] dmem_addr,
   input  logic                        dmem_wen,
   input  logic                        dmem_ren,
   input  word_t                       dmem_wdata,
   output word_t                       dmem_rdata
);

   word_t     if_instr;
   logic      stall;
   alu_op_e   ex_alu_op;
   logic      ex_alu_src;
   logic      ex_mem_write;
   logic      ex_mem_to_reg;
   logic      ex_reg_write;
   reg_addr_t ex_rs;
   reg_addr_t ex_rt;
   reg_addr_t ex_waddr;
   word_t     ex_rs_data;
   word_t     ex_rt_data;
   word_t     ex_imm;
   word_t     mem_alu_out;
   word_t     mem_store_data;
   logic      mem_mem_write;
   logic      mem_mem_to_reg;
   logic      mem_reg_write;
   reg_addr_t mem_waddr;
   logic      wb_reg_write;
   reg_addr_t wb_waddr;
   word_t     wb_wdata;

   fetch_stage u_fetch (
      .clk        (clk),
      .rst        (rst),
      .enable     (enable),
      .stall      (stall),
      .imem_wen   (imem_wen),
      .imem_addr  (imem_addr),
      .imem_wdata (imem_wdata),
      .if_instr   (if_instr)
   );

   decode_stage u_decode (
      .clk           (clk),
      .rst           (rst),
      .enable        (enable),
      .if_instr      (if_instr),
      .wb_reg_write  (wb_reg_write),
      .wb_waddr      (wb_waddr),
      .wb_wdata      (wb_wdata),
      .stall         (stall),
      .ex_alu_op     (ex_alu_op),
      .ex_alu_src    (ex_alu_src),
      .ex_mem_write  (ex_mem_write),
      .ex_mem_to_reg (ex_mem_to_reg),
      .ex_reg_write  (ex_reg_write),
      .ex_rs         (ex_rs),
      .ex_rt         (ex_rt),
      .ex_waddr      (ex_waddr),
      .ex_rs_data    (ex_rs_data),
      .ex_rt_data    (ex_rt_data),
      .ex_imm        (ex_imm)
   );

   execute_stage u_execute (
      .clk            (clk),
      .rst            (rst),
      .enable         (enable),
      .ex_alu_op      (ex_alu_op),
      .ex_alu_src     (ex_alu_src),
      .ex_mem_write   (ex_mem_write),
      .ex_mem_to_reg  (ex_mem_to_reg),
      .ex_reg_write   (ex_reg_write),
      .ex_rs          (ex_rs),
      .ex_rt          (ex_rt),
      .ex_waddr       (ex_waddr),
      .ex_rs_data     (ex_rs_data),
      .ex_rt_data     (ex_rt_data),
      .ex_imm         (ex_imm),
      .wb_reg_write   (wb_reg_write),
      .wb_waddr       (wb_waddr),
      .wb_wdata       (wb_wdata),
      .mem_alu_out    (mem_alu_out),
      .mem_store_data (mem_store_data),
      .mem_mem_write  (mem_mem_write),
      .mem_mem_to_reg (mem_mem_to_reg),
      .mem_reg_write  (mem_reg_write),
      .mem_waddr      (mem_waddr)
   );

   memory_stage u_memory (
      .clk            (clk),
      .rst            (rst),
      .enable         (enable),
      .mem_alu_out    (mem_alu_out),
      .mem_store_data (mem_store_data),
      .mem_mem_write  (mem_mem_write),
      .mem_mem_to_reg (mem_mem_to_reg),
      .mem_reg_write  (mem_reg_write),
      .mem_waddr      (mem_waddr),
      .dmem_addr      (dmem_addr),
      .dmem_wen       (dmem_wen),
      .dmem_ren       (dmem_ren),
      .dmem_wdata     (dmem_wdata),
      .dmem_rdata     (dmem_rdata),
      .wb_reg_write   (wb_reg_write),
      .wb_waddr       (wb_waddr),
      .wb_wdata       (wb_wdata)
   );

endmodule

// File: verification/cpu_tb.sv
/*
 * Table-driven testbench for the five-stage pipeline.
 * Each test resets the core, loads a short program and random data words 0..7,
 * runs with enable high and reads result words back over the external port.
 * Expected words come from a sequential model of the instruction set.
 * Programs may only touch data words 0..7.
 */
`timescale 1ns/1ps
`include "cpu_cfg.svh"

module cpu_tb import cpu_pkg::*; ();

   localparam int    num_tests = 8;
   localparam int    max_instr = 8;
   localparam int    imem_fill = 32;
   localparam int    imem_w    = `CPU_IMEM_ADDR_W;
   localparam int    dmem_w    = `CPU_DMEM_ADDR_W;
   localparam word_t nop       = '0;

   logic                clk;
   logic                rst;
   logic                enable;
   logic                imem_wen;
   logic [imem_w-1:0]   imem_addr;
   word_t               imem_wdata;
   logic [dmem_w-1:0]   dmem_addr;
   logic                dmem_wen;
   logic                dmem_ren;
   word_t               dmem_wdata;
   word_t               dmem_rdata;

   word_t               prog [num_tests][max_instr];
   int                  prog_len [num_tests];
   logic [dmem_w-1:0]   res_addr [num_tests][2];
   int                  num_res [num_tests];
   bit                  pause [num_tests];
   word_t               model_mem [8];
   int                  cycle_count;
   int                  cycle_limit;
   int                  check_count;
   int                  error_count;

   cpu u_cpu (
      .clk        (clk),
      .rst        (rst),
      .enable     (enable),
      .imem_wen   (imem_wen),
      .imem_addr  (imem_addr),
      .imem_wdata (imem_wdata),
      .dmem_addr  (dmem_addr),
      .dmem_wen   (dmem_wen),
      .dmem_ren   (dmem_ren),
      .dmem_wdata (dmem_wdata),
      .dmem_rdata (dmem_rdata)
   );

   always #4 clk = ~clk;

   always @(posedge clk) begin
      cycle_count++;
      if (cycle_count > cycle_limit) begin
         $display("timeout: run did not finish within %0d cycles", cycle_limit);
         $display("** FAIL **");
         $finish;
      end
   end

   function automatic word_t alu_instr(funct_e fn, reg_addr_t rd, reg_addr_t rs, reg_addr_t rt);
      return {OP_RTYPE, rs, rt, rd, 5'd0, fn};
   endfunction

   function automatic word_t addi_instr(reg_addr_t rt, reg_addr_t rs, logic [15:0] imm);
      return {OP_ADDI, rs, rt, imm};
   endfunction

   // loads and stores use r0 as the base
   function automatic word_t lw_instr(reg_addr_t rt, logic [15:0] offset);
      return {OP_LW, 5'd0, rt, offset};
   endfunction

   function automatic word_t sw_instr(reg_addr_t rt, logic [15:0] offset);
      return {OP_SW, 5'd0, rt, offset};
   endfunction

   task automatic describe_test(input int t, input int len, input logic [dmem_w-1:0] w0,
                                input logic [dmem_w-1:0] w1, input int nres, input bit p);
      prog_len[t]    = len;
      res_addr[t][0] = w0;
      res_addr[t][1] = w1;
      num_res[t]     = nres;
      pause[t]       = p;
      cycle_limit    = cycle_limit + 2 * (20 + imem_fill + len + 5 * int'(p) + nres);
   endtask

   task automatic load_table();
      cycle_limit = 0;
      // add and sub, then and and or, each after independent loads
      prog[0] = '{lw_instr(5'd1, 16'd0), lw_instr(5'd2, 16'd4), nop, nop,
                  alu_instr(FN_ADD, 5'd3, 5'd1, 5'd2), alu_instr(FN_SUB, 5'd4, 5'd1, 5'd2),
                  sw_instr(5'd3, 16'd8), sw_instr(5'd4, 16'd12)};
      describe_test(0, 8, 10'd2, 10'd3, 2, 1'b0);
      prog[1] = '{lw_instr(5'd1, 16'd0), lw_instr(5'd2, 16'd4), nop, nop,
                  alu_instr(FN_AND, 5'd3, 5'd1, 5'd2), alu_instr(FN_OR, 5'd4, 5'd1, 5'd2),
                  sw_instr(5'd3, 16'd8), sw_instr(5'd4, 16'd12)};
      describe_test(1, 8, 10'd2, 10'd3, 2, 1'b0);
      // -3 < 0 only holds as a signed compare
      prog[2] = '{lw_instr(5'd1, 16'd0), addi_instr(5'd2, 5'd0, 16'hfffd), nop, nop,
                  alu_instr(FN_SLT, 5'd3, 5'd2, 5'd0), alu_instr(FN_SLT, 5'd4, 5'd1, 5'd2),
                  sw_instr(5'd3, 16'd8), sw_instr(5'd4, 16'd12)};
      describe_test(2, 8, 10'd2, 10'd3, 2, 1'b0);
      // back to back on rs, then on rt, then a store of the last result
      prog[3] = '{lw_instr(5'd1, 16'd0), lw_instr(5'd2, 16'd4), nop, nop,
                  alu_instr(FN_ADD, 5'd3, 5'd1, 5'd2), alu_instr(FN_SUB, 5'd4, 5'd3, 5'd1),
                  alu_instr(FN_OR, 5'd5, 5'd2, 5'd4), sw_instr(5'd5, 16'd8)};
      describe_test(3, 8, 10'd2, 10'd0, 1, 1'b0);
      // distance two and three
      prog[4] = '{lw_instr(5'd1, 16'd0), lw_instr(5'd2, 16'd4), nop,
                  alu_instr(FN_ADD, 5'd3, 5'd1, 5'd2), nop,
                  alu_instr(FN_SUB, 5'd4, 5'd2, 5'd3), sw_instr(5'd3, 16'd8),
                  sw_instr(5'd4, 16'd12)};
      describe_test(4, 8, 10'd2, 10'd3, 2, 1'b0);
      // load-use into an add and into a store
      prog[5] = '{lw_instr(5'd1, 16'd0), lw_instr(5'd2, 16'd4),
                  alu_instr(FN_ADD, 5'd3, 5'd1, 5'd2), sw_instr(5'd3, 16'd8),
                  lw_instr(5'd4, 16'd12), sw_instr(5'd4, 16'd16), nop, nop};
      describe_test(5, 6, 10'd2, 10'd4, 2, 1'b0);
      // writes to r0 must not reach later readers
      prog[6] = '{lw_instr(5'd1, 16'd0), nop, nop, addi_instr(5'd0, 5'd1, 16'd7),
                  alu_instr(FN_ADD, 5'd0, 5'd1, 5'd1), alu_instr(FN_ADD, 5'd2, 5'd0, 5'd1),
                  sw_instr(5'd2, 16'd8), sw_instr(5'd0, 16'd12)};
      describe_test(6, 8, 10'd2, 10'd3, 2, 1'b0);
      prog[7] = prog[3];
      describe_test(7, 8, 10'd2, 10'd0, 1, 1'b1);
   endtask

   task automatic model_program(input int t);
      word_t     regs_m [32];
      word_t     instr;
      word_t     a;
      word_t     b;
      word_t     imm;
      word_t     addr;
      reg_addr_t rt;
      reg_addr_t rd;
      for (int r = 0; r < 32; r++) begin
         regs_m[r] = '0;
      end
      for (int i = 0; i < prog_len[t]; i++) begin
         instr = prog[t][i];
         a     = regs_m[instr[25:21]];
         b     = regs_m[instr[20:16]];
         rt    = instr[20:16];
         rd    = instr[15:11];
         imm   = {{16{instr[15]}}, instr[15:0]};
         addr  = a + imm;
         case (instr[31:26])
            OP_RTYPE: begin
               case (instr[5:0])
                  FN_ADD:  regs_m[rd] = a + b;
                  FN_SUB:  regs_m[rd] = a - b;
                  FN_AND:  regs_m[rd] = a & b;
                  FN_OR:   regs_m[rd] = a | b;
                  FN_SLT:  regs_m[rd] = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                  default: ;
               endcase
            end
            OP_ADDI: regs_m[rt] = addr;
            OP_LW:   regs_m[rt] = model_mem[addr[4:2]];
            OP_SW:   model_mem[addr[4:2]] = b;
            default: ;
         endcase
         regs_m[0] = '0;
      end
   endtask

   task automatic run_test(input int t);
      int                run_cycles;
      logic [dmem_w-1:0] idx;
      @(negedge clk);
      rst    = 1'b1;
      enable = 1'b0;
      repeat (3) @(negedge clk);
      rst = 1'b0;
      // program, then zero padding so the pipeline runs into no-ops
      for (int i = 0; i < imem_fill; i++) begin
         imem_wen  = 1'b1;
         imem_addr = imem_w'(i);
         if (i < prog_len[t]) begin
            imem_wdata = prog[t][i];
         end else begin
            imem_wdata = nop;
         end
         @(negedge clk);
      end
      imem_wen = 1'b0;
      for (int i = 0; i < 8; i++) begin
         dmem_wen     = 1'b1;
         dmem_addr    = dmem_w'(i);
         dmem_wdata   = $urandom;
         model_mem[i] = dmem_wdata;
         @(negedge clk);
      end
      dmem_wen = 1'b0;
      model_program(t);
      run_cycles = prog_len[t] + 8;
      enable     = 1'b1;
      for (int c = 0; c < run_cycles; c++) begin
         if (pause[t] && c == run_cycles / 2) begin
            enable = 1'b0;
            repeat (5) @(negedge clk);
            enable = 1'b1;
         end
         @(negedge clk);
      end
      enable = 1'b0;
      for (int k = 0; k < num_res[t]; k++) begin
         idx       = res_addr[t][k];
         dmem_ren  = 1'b1;
         dmem_addr = idx;
         @(posedge clk);
         check_count++;
         assert (dmem_rdata == model_mem[idx[2:0]]) else begin
            error_count++;
            $display("error: time %0t test %0d dmem_rdata at word %0d got %h expected %h",
                     $time, t, idx, dmem_rdata, model_mem[idx[2:0]]);
         end
         @(negedge clk);
      end
      dmem_ren = 1'b0;
   endtask

   initial begin
      clk         = 1'b0;
      rst         = 1'b1;
      enable      = 1'b0;
      imem_wen    = 1'b0;
      imem_addr   = '0;
      imem_wdata  = '0;
      dmem_addr   = '0;
      dmem_wen    = 1'b0;
      dmem_ren    = 1'b0;
      dmem_wdata  = '0;
      cycle_count = 0;
      check_count = 0;
      error_count = 0;
      void'($urandom(32'h4b8a));
      load_table();
      for (int t = 0; t < num_tests; t++) begin
         run_test(t);
      end
      $display("checks: %0d, errors: %0d", check_count, error_count);
      if (error_count == 0) begin
         $display("** PASS **");
      end else begin
         $display("** FAIL **");
      end
      $finish;
   end

endmodule

// File: compile.f
+incdir+include
design/cpu_pkg.sv
design/fetch_stage.sv
design/decode_stage.sv
design/execute_stage.sv
design/memory_stage.sv
design/cpu.sv
verification/cpu_tb.sv

// File: run_sim.sh
#!/bin/sh
# build and run the cpu testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f compile.f --top-module cpu_tb -o cpu_tb_sim
if [ $? -ne 0 ]; then
   echo "verilator build failed"
   exit 1
fi

output=$(./obj_dir/cpu_tb_sim)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
   echo "simulation exited with status $status"
   exit 1
fi

echo "$output" | grep -qF '** PASS **'
exit $?
